// ==== common/bmu_pkg.sv ====
//--------------------------------------
// Types shared by the bit-manipulation decode stage
// RV32 only, the immediate is one 32-bit data word
// Encodings follow the Zba/Zbb/Zbs subset listed below
//--------------------------------------
`default_nettype none

package bmu_pkg;

    //--------------------------------------
    // Basic words and instruction view
    //--------------------------------------

    typedef logic [31:0] data_word_t;
    typedef logic [4:0]  reg_idx_t;

    // R-type view of a 32-bit instruction, the quadrant sits in bits 1:0
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [4:0] opcode;
        logic [1:0] quadrant;
    } rtype_instr_t;

    // Major opcodes, instruction bits 6:2
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;

    // Only the uncompressed quadrant is decoded here
    localparam logic [1:0] QUADRANT_32BIT = 2'b11;

    //--------------------------------------
    // funct7 patterns
    //--------------------------------------

    // The single-bit patterns are reused by BEXT, REV8 and ORCB
    localparam logic [6:0] FUNCT7_BSET   = 7'b0010100;
    localparam logic [6:0] FUNCT7_BCLR   = 7'b0100100;
    localparam logic [6:0] FUNCT7_BINV   = 7'b0110100;
    localparam logic [6:0] FUNCT7_SHADD  = 7'b0010000;
    localparam logic [6:0] FUNCT7_MINMAX = 7'b0000101;

    //--------------------------------------
    // Operation classes and opcodes
    //--------------------------------------

    typedef enum logic [1:0] {
        LOGICOP,
        BYTEOP,
        SHADD,
        COMPARE
    } bmu_op_type_e;

    typedef enum logic [1:0] {
        BSET,
        BCLR,
        BINV,
        BEXT
    } logic_op_e;

    typedef enum logic [1:0] {
        REV8,
        ORCB
    } byte_op_e;

    typedef enum logic [1:0] {
        SH1ADD,
        SH2ADD,
        SH3ADD
    } shadd_op_e;

    typedef enum logic [1:0] {
        MIN,
        MINU,
        MAX,
        MAXU
    } cmp_op_e;

    // The same two bits, read according to op_type
    typedef union packed {
        logic_op_e logic_op;
        byte_op_e  byte_op;
        shadd_op_e shadd_op;
        cmp_op_e   cmp_op;
    } bmu_operation_u;

    typedef struct packed {
        bmu_op_type_e   op_type;
        bmu_operation_u select;
    } bmu_uop_t;

    //--------------------------------------
    // Decode results
    //--------------------------------------

    typedef struct packed {
        bmu_uop_t   uop;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        data_word_t immediate;
        logic       imm_valid;
    } decode_result_t;

    // Output of one form decoder, result is only meaningful when legal is set
    typedef struct packed {
        logic           legal;
        decode_result_t result;
    } sub_decode_t;

endpackage

`default_nettype wire

// ==== design/bmu_imm_decoder.sv ====
//--------------------------------------
// OP-IMM form decoder, purely combinational
// Checks funct3, funct7 and the rs2 field only
// The opcode and quadrant are checked by the parent
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bmu_imm_decoder
    import bmu_pkg::*;
(
    input  rtype_instr_t instr_i,
    output sub_decode_t  imm_dec_o
);

    // Full imm[11:0] of the byte operations
    localparam logic [11:0] IMM_REV8 = 12'h698;
    localparam logic [11:0] IMM_ORCB = 12'h287;

    logic           legal;
    logic           has_imm;
    bmu_op_type_e   op_type;
    bmu_operation_u op;
    logic [11:0]    imm_field;

    assign imm_field = {instr_i.funct7, instr_i.rs2};

    //--------------------------------------
    // funct decode
    //--------------------------------------

    always_comb begin : funct_decode
        legal   = 1'b0;
        has_imm = 1'b0;
        op_type = LOGICOP;
        op      = '0;
        case (instr_i.funct3)
            3'b001: begin
                // Single-bit ops take the shift amount from the rs2 slot
                has_imm = 1'b1;
                case (instr_i.funct7)
                    FUNCT7_BSET: begin
                        legal       = 1'b1;
                        op.logic_op = BSET;
                    end
                    FUNCT7_BCLR: begin
                        legal       = 1'b1;
                        op.logic_op = BCLR;
                    end
                    FUNCT7_BINV: begin
                        legal       = 1'b1;
                        op.logic_op = BINV;
                    end
                    default: has_imm = 1'b0;
                endcase
            end
            3'b101: begin
                if (instr_i.funct7 == FUNCT7_BCLR) begin
                    legal       = 1'b1;
                    has_imm     = 1'b1;
                    op.logic_op = BEXT;
                end else if (imm_field == IMM_REV8) begin
                    legal      = 1'b1;
                    op_type    = BYTEOP;
                    op.byte_op = REV8;
                end else if (imm_field == IMM_ORCB) begin
                    legal      = 1'b1;
                    op_type    = BYTEOP;
                    op.byte_op = ORCB;
                end
            end
            default: legal = 1'b0;
        endcase
    end : funct_decode

    // rs2 is never a register source in this form
    always_comb begin : result_pack
        imm_dec_o                     = '0;
        imm_dec_o.legal               = legal;
        imm_dec_o.result.uop.op_type  = op_type;
        imm_dec_o.result.uop.select   = op;
        imm_dec_o.result.rs1          = instr_i.rs1;
        imm_dec_o.result.rd           = instr_i.rd;
        imm_dec_o.result.imm_valid    = has_imm;
        if (has_imm) begin
            imm_dec_o.result.immediate = {27'b0, instr_i.rs2};
        end
    end : result_pack

endmodule

`default_nettype wire

// ==== design/bmu_reg_decoder.sv ====
//--------------------------------------
// OP form decoder, purely combinational
// Checks funct3 and funct7 against exact encodings
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bmu_reg_decoder
    import bmu_pkg::*;
(
    input  rtype_instr_t instr_i,
    output sub_decode_t  reg_dec_o
);

    logic           legal;
    bmu_op_type_e   op_type;
    bmu_operation_u op;

    //--------------------------------------
    // funct decode
    //--------------------------------------

    always_comb begin : funct_decode
        legal   = 1'b0;
        op_type = LOGICOP;
        op      = '0;
        case (instr_i.funct3)
            3'b001: begin
                case (instr_i.funct7)
                    FUNCT7_BSET: begin
                        legal       = 1'b1;
                        op.logic_op = BSET;
                    end
                    FUNCT7_BCLR: begin
                        legal       = 1'b1;
                        op.logic_op = BCLR;
                    end
                    FUNCT7_BINV: begin
                        legal       = 1'b1;
                        op.logic_op = BINV;
                    end
                    default: legal = 1'b0;
                endcase
            end
            3'b010: begin
                if (instr_i.funct7 == FUNCT7_SHADD) begin
                    legal       = 1'b1;
                    op_type     = SHADD;
                    op.shadd_op = SH1ADD;
                end
            end
            3'b100: begin
                case (instr_i.funct7)
                    FUNCT7_SHADD: begin
                        legal       = 1'b1;
                        op_type     = SHADD;
                        op.shadd_op = SH2ADD;
                    end
                    FUNCT7_MINMAX: begin
                        legal     = 1'b1;
                        op_type   = COMPARE;
                        op.cmp_op = MIN;
                    end
                    default: legal = 1'b0;
                endcase
            end
            3'b101: begin
                case (instr_i.funct7)
                    FUNCT7_MINMAX: begin
                        legal     = 1'b1;
                        op_type   = COMPARE;
                        op.cmp_op = MINU;
                    end
                    FUNCT7_BCLR: begin
                        legal       = 1'b1;
                        op.logic_op = BEXT;
                    end
                    default: legal = 1'b0;
                endcase
            end
            3'b110: begin
                case (instr_i.funct7)
                    FUNCT7_MINMAX: begin
                        legal     = 1'b1;
                        op_type   = COMPARE;
                        op.cmp_op = MAX;
                    end
                    FUNCT7_SHADD: begin
                        legal       = 1'b1;
                        op_type     = SHADD;
                        op.shadd_op = SH3ADD;
                    end
                    default: legal = 1'b0;
                endcase
            end
            3'b111: begin
                if (instr_i.funct7 == FUNCT7_MINMAX) begin
                    legal     = 1'b1;
                    op_type   = COMPARE;
                    op.cmp_op = MAXU;
                end
            end
            default: legal = 1'b0;
        endcase
    end : funct_decode

    //--------------------------------------
    // Result
    //--------------------------------------

    // Both sources are registers, the immediate stays zero
    always_comb begin : result_pack
        reg_dec_o                    = '0;
        reg_dec_o.legal              = legal;
        reg_dec_o.result.uop.op_type = op_type;
        reg_dec_o.result.uop.select  = op;
        reg_dec_o.result.rs1         = instr_i.rs1;
        reg_dec_o.result.rs2         = instr_i.rs2;
        reg_dec_o.result.rd          = instr_i.rd;
    end : result_pack

endmodule

`default_nettype wire

// ==== design/bmu_decoder.sv ====
//--------------------------------------
// Bit-manipulation decode stage, one cycle latency
// One strobe per cycle accepted, no back-pressure
// decode_o holds its last value between strobes
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bmu_decoder
    import bmu_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           instr_valid_i,
    input  rtype_instr_t   instr_i,
    output logic           decode_valid_o,
    output decode_result_t decode_o,
    output logic           exception_o
);

    sub_decode_t    imm_dec;
    sub_decode_t    reg_dec;
    logic           form_legal;
    decode_result_t form_result;
    logic           instr_legal;

    //--------------------------------------
    // Form decoders
    //--------------------------------------

    bmu_imm_decoder u_imm_decoder (
        .instr_i   (instr_i),
        .imm_dec_o (imm_dec)
    );

    bmu_reg_decoder u_reg_decoder (
        .instr_i   (instr_i),
        .reg_dec_o (reg_dec)
    );

    // Pick the form by major opcode, anything else is illegal
    always_comb begin : form_select
        form_legal  = 1'b0;
        form_result = '0;
        case (instr_i.opcode)
            OPC_OP_IMM: begin
                form_legal  = imm_dec.legal;
                form_result = imm_dec.result;
            end
            OPC_OP: begin
                form_legal  = reg_dec.legal;
                form_result = reg_dec.result;
            end
            default: form_legal = 1'b0;
        endcase
    end : form_select

    assign instr_legal = (instr_i.quadrant == QUADRANT_32BIT) && form_legal;

    //--------------------------------------
    // Output register stage
    //--------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            decode_valid_o <= 1'b0;
            exception_o    <= 1'b0;
            decode_o       <= '0;
        end else begin
            decode_valid_o <= instr_valid_i && instr_legal;
            exception_o    <= instr_valid_i && !instr_legal;
            // An illegal instruction leaves an all-zero result behind
            if (instr_valid_i) begin
                decode_o <= instr_legal ? form_result : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/bmu_decoder_assertions.sv ====
//--------------------------------------
// Protocol checks on the decode stage outputs
// Bound into every bmu_decoder instance, inactive during reset
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bmu_decoder_assertions
    import bmu_pkg::*;
(
    input logic           clk_i,
    input logic           rst_n_i,
    input logic           instr_valid_i,
    input logic           decode_valid_o,
    input logic           exception_o,
    input decode_result_t decode_o
);

    // Number of assertion failures seen so far
    int unsigned fail_count = 0;

    // A result and an exception never come out together
    a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(decode_valid_o && exception_o))
    else begin
        $error("decode_valid_o and exception_o are high together");
        fail_count++;
    end

    // Any response belongs to a strobe one cycle earlier
    a_response_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (decode_valid_o || exception_o) |-> $past(instr_valid_i))
    else begin
        $error("Response flag without a strobe one cycle earlier");
        fail_count++;
    end

    a_imm_only_logic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        decode_o.imm_valid |-> (decode_o.uop.op_type == LOGICOP))
    else begin
        $error("imm_valid is set outside the logic class");
        fail_count++;
    end

endmodule

bind bmu_decoder bmu_decoder_assertions u_assertions (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .decode_valid_o (decode_valid_o),
    .exception_o    (exception_o),
    .decode_o       (decode_o)
);

`default_nettype wire

// ==== testbench/tb_bmu_decoder.sv ====
//--------------------------------------
// Directed tests for the decode stage
// Inputs change on the falling edge, outputs are sampled there too
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_bmu_decoder
    import bmu_pkg::*;
();

    localparam int          NUM_KINDS    = 17;
    localparam int          RESP_TIMEOUT = 8;
    localparam logic [31:0] SEED         = 32'h67a5c465;

    // One row per legal instruction, kinds 0 to 5 are the OP-IMM forms
    typedef struct packed {
        logic         imm_form;
        logic [2:0]   funct3;
        logic [6:0]   funct7;
        bmu_op_type_e op_type;
        logic [1:0]   op;
    } kind_row_t;

    logic           clk;
    logic           rst_n_i;
    logic           instr_valid_i;
    rtype_instr_t   instr_i;
    logic           decode_valid_o;
    decode_result_t decode_o;
    logic           exception_o;
    logic [31:0]    rng_state;

    bmu_decoder u_bmu_decoder (
        .clk_i          (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .decode_valid_o (decode_valid_o),
        .decode_o       (decode_o),
        .exception_o    (exception_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end : clock_gen

    //--------------------------------------
    // Reference model
    //--------------------------------------

    function automatic kind_row_t kind_row(int kind);
        case (kind)
            0:       return '{1'b1, 3'b001, 7'b0010100, LOGICOP, BSET};
            1:       return '{1'b1, 3'b001, 7'b0100100, LOGICOP, BCLR};
            2:       return '{1'b1, 3'b001, 7'b0110100, LOGICOP, BINV};
            3:       return '{1'b1, 3'b101, 7'b0100100, LOGICOP, BEXT};
            4:       return '{1'b1, 3'b101, 7'b0110100, BYTEOP, REV8};
            5:       return '{1'b1, 3'b101, 7'b0010100, BYTEOP, ORCB};
            6:       return '{1'b0, 3'b001, 7'b0010100, LOGICOP, BSET};
            7:       return '{1'b0, 3'b001, 7'b0100100, LOGICOP, BCLR};
            8:       return '{1'b0, 3'b001, 7'b0110100, LOGICOP, BINV};
            9:       return '{1'b0, 3'b101, 7'b0100100, LOGICOP, BEXT};
            10:      return '{1'b0, 3'b010, 7'b0010000, SHADD, SH1ADD};
            11:      return '{1'b0, 3'b100, 7'b0010000, SHADD, SH2ADD};
            12:      return '{1'b0, 3'b110, 7'b0010000, SHADD, SH3ADD};
            13:      return '{1'b0, 3'b100, 7'b0000101, COMPARE, MIN};
            14:      return '{1'b0, 3'b101, 7'b0000101, COMPARE, MINU};
            15:      return '{1'b0, 3'b110, 7'b0000101, COMPARE, MAX};
            default: return '{1'b0, 3'b111, 7'b0000101, COMPARE, MAXU};
        endcase
    endfunction

    function automatic rtype_instr_t encode(int kind, reg_idx_t rs1, reg_idx_t rs2, reg_idx_t rd);
        kind_row_t    row;
        rtype_instr_t instr;
        row            = kind_row(kind);
        instr.funct7   = row.funct7;
        instr.rs2      = rs2;
        instr.rs1      = rs1;
        instr.funct3   = row.funct3;
        instr.rd       = rd;
        instr.opcode   = row.imm_form ? 5'b00100 : 5'b01100;
        instr.quadrant = 2'b11;
        // REV8 and ORCB fix imm[11:0] to 698 and 287 hex
        if (kind == 4) instr.rs2 = 5'b11000;
        if (kind == 5) instr.rs2 = 5'b00111;
        return instr;
    endfunction

    // Legal only when the word is exactly one of the listed encodings
    function automatic sub_decode_t predict(rtype_instr_t instr);
        sub_decode_t exp;
        kind_row_t   row;
        exp = '0;
        for (int k = 0; k < NUM_KINDS; k++) begin
            row = kind_row(k);
            if (instr == encode(k, instr.rs1, instr.rs2, instr.rd)) begin
                exp.legal                  = 1'b1;
                exp.result.uop.op_type     = row.op_type;
                exp.result.uop.select      = row.op;
                exp.result.rs1             = instr.rs1;
                exp.result.rs2             = row.imm_form ? 5'd0 : instr.rs2;
                exp.result.rd              = instr.rd;
                exp.result.imm_valid       = row.imm_form && (row.op_type == LOGICOP);
                exp.result.immediate       = exp.result.imm_valid ? {27'd0, instr.rs2} : '0;
            end
        end
        return exp;
    endfunction

    // Xorshift32 step on the shared generator state
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    //--------------------------------------
    // Checks
    //--------------------------------------

    task automatic fail_run(string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_result(decode_result_t got, decode_result_t exp, string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0d ns: %s decode_o %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string name, string what);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0d ns: %s %s is %b, expected %b",
                               $time, what, name, got, exp));
        end
    endtask

    // Starts and ends on a falling edge and leaves one idle cycle after the response
    task automatic drive_and_check(rtype_instr_t instr, string what);
        sub_decode_t exp;
        int          waited;
        exp           = predict(instr);
        instr_i       = instr;
        instr_valid_i = 1'b1;
        @(negedge clk);
        instr_valid_i = 1'b0;
        // A different word without a strobe must not reach decode_o
        instr_i       = ~instr;
        waited        = 1;
        while (!decode_valid_o && !exception_o) begin
            if (waited >= RESP_TIMEOUT) begin
                fail_run($sformatf("Timeout: no response to %s within %0d cycles",
                                   what, RESP_TIMEOUT));
            end
            @(negedge clk);
            waited++;
        end
        if (waited != 1) begin
            fail_run($sformatf("Response to %s came after %0d cycles, not one", what, waited));
        end
        check_flag(decode_valid_o, exp.legal, "decode_valid_o", what);
        check_flag(exception_o, !exp.legal, "exception_o", what);
        check_result(decode_o, exp.result, what);
        @(negedge clk);
        check_flag(decode_valid_o, 1'b0, "decode_valid_o", $sformatf("%s idle", what));
        check_flag(exception_o, 1'b0, "exception_o", $sformatf("%s idle", what));
        check_result(decode_o, exp.result, $sformatf("%s held", what));
    endtask

    task automatic expect_illegal(rtype_instr_t instr, string what);
        sub_decode_t exp;
        exp = predict(instr);
        if (exp.legal) fail_run($sformatf("Stimulus for %s is a legal encoding", what));
        drive_and_check(instr, what);
    endtask

    //--------------------------------------
    // Tests
    //--------------------------------------

    task automatic reset_test();
        repeat (16) @(negedge clk);
        check_flag(decode_valid_o, 1'b0, "decode_valid_o", "in reset");
        check_flag(exception_o, 1'b0, "exception_o", "in reset");
        check_result(decode_o, '0, "in reset");
        rst_n_i = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_flag(decode_valid_o, 1'b0, "decode_valid_o", "idle after reset");
            check_flag(exception_o, 1'b0, "exception_o", "idle after reset");
            check_result(decode_o, '0, "idle after reset");
        end
    endtask

    task automatic form_test(int first, int last);
        logic [31:0] r;
        for (int k = first; k <= last; k++) begin
            r = next_random();
            drive_and_check(encode(k, r[4:0], r[9:5], r[14:10]), $sformatf("kind %0d", k));
        end
    endtask

    task automatic illegal_test();
        rtype_instr_t instr;
        instr = encode(6, 5'd1, 5'd2, 5'd3);
        instr.quadrant = 2'b01;
        expect_illegal(instr, "quadrant 01");
        instr = encode(0, 5'd4, 5'd5, 5'd6);
        instr.opcode = 5'b00000;
        expect_illegal(instr, "load opcode");
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int form = 0; form < 2; form++) begin
                instr        = encode(form * 6, 5'd7, 5'd8, 5'd9);
                instr.funct3 = 3'(f3);
                instr.funct7 = 7'b1111111;
                expect_illegal(instr, $sformatf("funct7 7f, funct3 %0d, form %0d", f3, form));
            end
        end
        instr = encode(4, 5'd10, 5'd0, 5'd11);
        instr.rs2 = 5'b11001;
        expect_illegal(instr, "REV8 with imm 699");
        instr = encode(5, 5'd12, 5'd0, 5'd13);
        instr.rs2 = 5'b00110;
        expect_illegal(instr, "ORCB with imm 286");
    endtask

    // Each cycle checks the previous cycle's instruction and drives the next one
    task automatic stream_test();
        rtype_instr_t prev;
        rtype_instr_t cur;
        sub_decode_t  exp;
        logic [31:0]  r;
        logic [31:0]  s;
        for (int i = 0; i <= 200; i++) begin
            if (i > 0) begin
                exp = predict(prev);
                check_flag(decode_valid_o, exp.legal, "decode_valid_o", "stream");
                check_flag(exception_o, !exp.legal, "exception_o", "stream");
                check_result(decode_o, exp.result, "stream");
            end
            if (i < 200) begin
                r   = next_random();
                s   = next_random();
                cur = encode(r % NUM_KINDS, s[4:0], s[9:5], s[14:10]);
                // Flip one bit about half the time
                if (r[31]) cur[r[30:26]] = ~cur[r[30:26]];
                instr_i       = cur;
                instr_valid_i = 1'b1;
                prev          = cur;
            end else begin
                instr_valid_i = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    initial begin : main
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rng_state     = SEED;
        reset_test();
        form_test(0, 5);
        form_test(6, NUM_KINDS - 1);
        illegal_test();
        stream_test();
        if (u_bmu_decoder.u_assertions.fail_count != 0) begin
            fail_run("A bound protocol assertion failed during the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end : main

endmodule

`default_nettype wire

// ==== vlog.f ====
common/bmu_pkg.sv
design/bmu_imm_decoder.sv
design/bmu_reg_decoder.sv
design/bmu_decoder.sv
testbench/bmu_decoder_assertions.sv
testbench/tb_bmu_decoder.sv

// ==== Bender.yml ====
package:
  name: bmu_decoder

sources:
  - common/bmu_pkg.sv
  - design/bmu_imm_decoder.sv
  - design/bmu_reg_decoder.sv
  - design/bmu_decoder.sv
  - target: test
    files:
      - testbench/bmu_decoder_assertions.sv
      - testbench/tb_bmu_decoder.sv
